//--- include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// machine word and reset state
`define RV_XLEN         32
`define RV_RESET_PC     32'h4000_0000
`define RV_NOP          32'h0000_0013
`define RV_CSR_TOHOST   12'h51e

// major opcodes
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_SYSTEM   7'b1110011

// funct3 for OP and OP-IMM
`define RV_F3_ADD       3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SR        3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

// funct3 for branches
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_BLT       3'b100
`define RV_F3_BGE       3'b101
`define RV_F3_BLTU      3'b110
`define RV_F3_BGEU      3'b111

// funct3 for the CSR writes
`define RV_F3_CSRRW     3'b001
`define RV_F3_CSRRWI    3'b101

`endif

//--- design/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    // register-register view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // immediate view, also carries the CSR number
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu      = 2'd0,
        wb_pc_plus4 = 2'd1,
        wb_none     = 2'd2
    } wb_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    a_is_pc;
        logic    b_is_imm;
        logic    is_branch;
        logic    is_jalr;
        logic    csr_write;
        logic    csr_imm;
        logic    reg_write;
        wb_sel_t wb_sel;
        logic    br_unsigned;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        inst_t               inst;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
        logic [`RV_XLEN-1:0] imm;
        dec_ctrl_t           ctrl;
    } dec_stage_t;

    typedef struct packed {
        logic [4:0]          rd;
        logic                reg_write;
        wb_sel_t             wb_sel;
        logic [`RV_XLEN-1:0] alu_val;
        logic [`RV_XLEN-1:0] pc;
        logic                csr_write;
        logic [`RV_XLEN-1:0] csr_val;
    } exe_stage_t;

endpackage

`default_nettype wire

//--- design/rv_fetch.sv
`default_nettype none

`include "rv_defines.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                jal_taken,
    input  logic [`RV_XLEN-1:0] jal_pc,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic [`RV_XLEN-1:0] inst_addr,
    output logic [`RV_XLEN-1:0] fetch_pc
);
    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_next;

    // execute redirect wins over a JAL sitting in decode
    always_comb begin
        if (reset) begin
            pc_next = `RV_RESET_PC;
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else if (jal_taken) begin
            pc_next = jal_pc;
        end else begin
            pc_next = pc_q + 'd4;
        end
    end

    // memory registers inst_addr, so pc_q lines up with inst_data
    always_ff @(posedge clk) begin
        pc_q <= pc_next;
    end

    assign inst_addr = pc_next;
    assign fetch_pc  = pc_q;

endmodule

`default_nettype wire

//--- design/rv_reg_file.sv
`default_nettype none

`include "rv_defines.svh"

module rv_reg_file (
    input  logic                clk,
    input  logic                we,
    input  logic [4:0]          wa,
    input  logic [4:0]          ra1,
    input  logic [4:0]          ra2,
    input  logic [`RV_XLEN-1:0] wd,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);
    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    // result stage filters out x0 writes before they get here
    assert property (@(posedge clk) !(we && wa == 5'd0));

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`default_nettype none

`include "rv_defines.svh"

module rv_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_XLEN-1:0] fetch_pc,
    input  logic [`RV_XLEN-1:0] inst_data,
    input  logic                flush,
    output logic [4:0]          ra1,
    output logic [4:0]          ra2,
    input  logic [`RV_XLEN-1:0] rd1,
    input  logic [`RV_XLEN-1:0] rd2,
    input  logic                wb_we,
    input  logic [4:0]          wb_rd,
    input  logic [`RV_XLEN-1:0] wb_val,
    output logic                jal_taken,
    output logic [`RV_XLEN-1:0] jal_pc,
    output rv_pkg::dec_stage_t  dec
);
    rv_pkg::inst_t       inst;
    rv_pkg::dec_ctrl_t   ctrl;
    logic [`RV_XLEN-1:0] imm_i, imm_u, imm_b, imm_j, imm_csr, imm;
    logic [`RV_XLEN-1:0] rs1_val, rs2_val;

    function automatic rv_pkg::alu_op_t alu_fn(input logic [2:0] f3, input logic alt);
        case (f3)
            `RV_F3_ADD:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            `RV_F3_SLL:  return rv_pkg::alu_sll;
            `RV_F3_SLT:  return rv_pkg::alu_slt;
            `RV_F3_SLTU: return rv_pkg::alu_sltu;
            `RV_F3_XOR:  return rv_pkg::alu_xor;
            `RV_F3_SR:   return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            `RV_F3_OR:   return rv_pkg::alu_or;
            default:     return rv_pkg::alu_and;
        endcase
    endfunction

    // slot behind a taken branch or JALR becomes a NOP
    assign inst = flush ? `RV_NOP : inst_data;
    assign ra1  = inst.r.rs1;
    assign ra2  = inst.r.rs2;

    // same-cycle write-back bypass
    assign rs1_val = (wb_we && wb_rd == ra1) ? wb_val : rd1;
    assign rs2_val = (wb_we && wb_rd == ra2) ? wb_val : rd2;

    assign imm_i   = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_u   = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
    assign imm_b   = {{20{inst.r.funct7[6]}}, inst.r.rd[0], inst.r.funct7[5:0],
                      inst.r.rd[4:1], 1'b0};
    assign imm_j   = {{12{inst.r.funct7[6]}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                      inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};
    // CSRRWI source sits in the rs1 field
    assign imm_csr = {27'b0, inst.r.rs1};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_pkg::alu_add;
        ctrl.wb_sel = rv_pkg::wb_none;
        imm         = imm_i;
        case (inst.r.opcode)
            `RV_OPC_OP: begin
                ctrl.alu_op    = alu_fn(inst.r.funct3, inst.r.funct7[5]);
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_alu;
            end
            `RV_OPC_OP_IMM: begin
                // only srai uses the funct7 bit
                ctrl.alu_op    = alu_fn(inst.i.funct3,
                                        inst.i.funct3 == `RV_F3_SR && inst.r.funct7[5]);
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_alu;
            end
            `RV_OPC_LUI, `RV_OPC_AUIPC: begin
                ctrl.alu_op    = (inst.r.opcode == `RV_OPC_LUI) ? rv_pkg::alu_pass_b
                                                                : rv_pkg::alu_add;
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_alu;
                imm            = imm_u;
            end
            `RV_OPC_JAL, `RV_OPC_JALR: begin
                ctrl.is_jalr   = (inst.r.opcode == `RV_OPC_JALR);
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_pc_plus4;
                imm            = (inst.r.opcode == `RV_OPC_JAL) ? imm_j : imm_i;
            end
            `RV_OPC_BRANCH: begin
                ctrl.is_branch   = 1'b1;
                ctrl.br_unsigned = (inst.r.funct3 == `RV_F3_BLTU) ||
                                   (inst.r.funct3 == `RV_F3_BGEU);
                imm              = imm_b;
            end
            `RV_OPC_SYSTEM: begin
                // only tohost exists, rd gets nothing back
                ctrl.csr_write = (inst.i.imm12 == `RV_CSR_TOHOST) &&
                                 (inst.i.funct3 == `RV_F3_CSRRW ||
                                  inst.i.funct3 == `RV_F3_CSRRWI);
                ctrl.csr_imm   = (inst.i.funct3 == `RV_F3_CSRRWI);
                imm            = imm_csr;
            end
            default: begin
            end
        endcase
    end

    // JAL resolves here, nothing behind it is squashed
    assign jal_taken = (inst.r.opcode == `RV_OPC_JAL);
    assign jal_pc    = fetch_pc + imm_j;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.inst <= `RV_NOP;
            dec.ctrl <= '0;
        end else begin
            dec.inst <= inst;
            dec.ctrl <= ctrl;
        end
        dec.pc      <= fetch_pc;
        dec.rs1_val <= rs1_val;
        dec.rs2_val <= rs2_val;
        dec.imm     <= imm;
    end

endmodule

`default_nettype wire

//--- design/rv_execute.sv
`default_nettype none

`include "rv_defines.svh"

module rv_execute (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::dec_stage_t  dec,
    input  logic [4:0]          fwd_rd,
    input  logic                fwd_we,
    input  logic [`RV_XLEN-1:0] fwd_val,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc,
    output logic                flush,
    output rv_pkg::exe_stage_t  exe
);
    logic [`RV_XLEN-1:0] rs1_val, rs2_val;
    logic [`RV_XLEN-1:0] op_a, op_b;
    logic [`RV_XLEN-1:0] alu_val;
    logic [`RV_XLEN-1:0] br_target;
    logic [4:0]          shamt;
    logic                br_eq, br_lt, br_taken;

    // previous instruction is in the result register
    assign rs1_val = (fwd_we && fwd_rd == dec.inst.r.rs1) ? fwd_val : dec.rs1_val;
    assign rs2_val = (fwd_we && fwd_rd == dec.inst.r.rs2) ? fwd_val : dec.rs2_val;

    assign op_a  = dec.ctrl.a_is_pc  ? dec.pc  : rs1_val;
    assign op_b  = dec.ctrl.b_is_imm ? dec.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.ctrl.alu_op)
            rv_pkg::alu_sub:    alu_val = op_a - op_b;
            rv_pkg::alu_sll:    alu_val = op_a << shamt;
            rv_pkg::alu_slt:    alu_val = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_val = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::alu_xor:    alu_val = op_a ^ op_b;
            rv_pkg::alu_srl:    alu_val = op_a >> shamt;
            rv_pkg::alu_sra:    alu_val = $signed(op_a) >>> shamt;
            rv_pkg::alu_or:     alu_val = op_a | op_b;
            rv_pkg::alu_and:    alu_val = op_a & op_b;
            rv_pkg::alu_pass_b: alu_val = op_b;
            default:            alu_val = op_a + op_b;
        endcase
    end

    // branch compare always on the register operands
    assign br_eq = (rs1_val == rs2_val);
    assign br_lt = dec.ctrl.br_unsigned ? (rs1_val < rs2_val)
                                        : ($signed(rs1_val) < $signed(rs2_val));

    always_comb begin
        case (dec.inst.r.funct3)
            `RV_F3_BEQ:               br_taken = br_eq;
            `RV_F3_BNE:               br_taken = !br_eq;
            `RV_F3_BLT, `RV_F3_BLTU:  br_taken = br_lt;
            `RV_F3_BGE, `RV_F3_BGEU:  br_taken = !br_lt;
            default:                  br_taken = 1'b0;
        endcase
    end

    assign br_target   = dec.pc + dec.imm;
    assign redirect    = (dec.ctrl.is_branch && br_taken) || dec.ctrl.is_jalr;
    assign flush       = redirect;
    // JALR target drops bit 0
    assign redirect_pc = dec.ctrl.is_jalr ? {alu_val[`RV_XLEN-1:1], 1'b0} : br_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe.reg_write <= 1'b0;
            exe.csr_write <= 1'b0;
        end else begin
            exe.reg_write <= dec.ctrl.reg_write;
            exe.csr_write <= dec.ctrl.csr_write;
        end
        exe.rd      <= dec.inst.r.rd;
        exe.wb_sel  <= dec.ctrl.wb_sel;
        exe.alu_val <= alu_val;
        exe.pc      <= dec.pc;
        exe.csr_val <= dec.ctrl.csr_imm ? dec.imm : rs1_val;
    end

    // the squashed slot behind a redirect can never redirect again
    assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect);

endmodule

`default_nettype wire

//--- design/rv_result.sv
`default_nettype none

`include "rv_defines.svh"

module rv_result (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::exe_stage_t  exe,
    output logic                we,
    output logic [4:0]          wa,
    output logic [`RV_XLEN-1:0] wd,
    output logic [4:0]          fwd_rd,
    output logic                fwd_we,
    output logic [`RV_XLEN-1:0] fwd_val,
    output logic [`RV_XLEN-1:0] tohost,
    output logic                tohost_valid
);
    logic [`RV_XLEN-1:0] wb_val;
    logic [`RV_XLEN-1:0] tohost_q;

    // link value for JAL and JALR
    always_comb begin
        case (exe.wb_sel)
            rv_pkg::wb_pc_plus4: wb_val = exe.pc + 'd4;
            default:             wb_val = exe.alu_val;
        endcase
    end

    // the only place x0 writes are dropped
    assign we      = exe.reg_write && (exe.rd != 5'd0);
    assign wa      = exe.rd;
    assign wd      = wb_val;
    assign fwd_we  = we;
    assign fwd_rd  = exe.rd;
    assign fwd_val = wb_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            tohost_q <= '0;
        end else if (exe.csr_write) begin
            tohost_q <= exe.csr_val;
        end
    end

    // new value shows in the cycle of the write
    assign tohost       = exe.csr_write ? exe.csr_val : tohost_q;
    assign tohost_valid = exe.csr_write;

    assert property (@(posedge clk) reset && $past(reset) |-> !tohost_valid);

endmodule

`default_nettype wire

//--- design/rv_core.sv
`default_nettype none

`include "rv_defines.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset,
    output logic [`RV_XLEN-1:0] inst_addr,
    input  logic [`RV_XLEN-1:0] inst_data,
    output logic [`RV_XLEN-1:0] tohost,
    output logic                tohost_valid
);
    logic [`RV_XLEN-1:0] fetch_pc, jal_pc, redirect_pc;
    logic                jal_taken, redirect, flush;
    logic [4:0]          ra1, ra2, wa, fwd_rd;
    logic [`RV_XLEN-1:0] rd1, rd2, wd, fwd_val;
    logic                we, fwd_we;
    rv_pkg::dec_stage_t  dec;
    rv_pkg::exe_stage_t  exe;

    rv_fetch u_fetch (
        .clk(clk), .reset(reset),
        .jal_taken(jal_taken), .jal_pc(jal_pc),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .inst_addr(inst_addr), .fetch_pc(fetch_pc)
    );

    rv_decode u_decode (
        .clk(clk), .reset(reset),
        .fetch_pc(fetch_pc), .inst_data(inst_data), .flush(flush),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .wb_we(we), .wb_rd(wa), .wb_val(wd),
        .jal_taken(jal_taken), .jal_pc(jal_pc),
        .dec(dec)
    );

    rv_execute u_execute (
        .clk(clk), .reset(reset), .dec(dec),
        .fwd_rd(fwd_rd), .fwd_we(fwd_we), .fwd_val(fwd_val),
        .redirect(redirect), .redirect_pc(redirect_pc), .flush(flush),
        .exe(exe)
    );

    rv_result u_result (
        .clk(clk), .reset(reset), .exe(exe),
        .we(we), .wa(wa), .wd(wd),
        .fwd_rd(fwd_rd), .fwd_we(fwd_we), .fwd_val(fwd_val),
        .tohost(tohost), .tohost_valid(tohost_valid)
    );

    rv_reg_file u_reg_file (
        .clk(clk), .we(we), .wa(wa), .ra1(ra1), .ra2(ra2),
        .wd(wd), .rd1(rd1), .rd2(rd2)
    );

endmodule

`default_nettype wire

//--- bench/rv_core_tb.sv
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                clk = 1'b0;
    logic                reset;
    logic [`RV_XLEN-1:0] inst_addr;
    logic [`RV_XLEN-1:0] inst_data;
    logic [`RV_XLEN-1:0] tohost;
    logic                tohost_valid;

    logic [31:0] rng_state = 32'haf3e4587;
    logic [31:0] addr_q = `RV_RESET_PC;
    logic [31:0] prog[$];
    string       names[$];
    logic [31:0] exp_val[$];
    string       exp_name[$];
    int          errors = 0;
    int          checked = 0;
    bit          done = 1'b0;

    localparam logic [31:0] END_WORD = {20'b0, 5'd0, `RV_OPC_JAL};

    rv_core DUT (
        .clk(clk), .reset(reset), .inst_addr(inst_addr), .inst_data(inst_data),
        .tohost(tohost), .tohost_valid(tohost_valid)
    );

    always #5 clk = ~clk;

    // instruction port with one cycle of read latency
    always @(posedge clk) addr_q <= inst_addr;

    always @(negedge clk) begin
        logic [31:0] widx;
        widx = (addr_q - `RV_RESET_PC) >> 2;
        inst_data <= (widx < prog.size()) ? prog[widx] : `RV_NOP;
    end

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(next_rand() % 31 + 1);
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OPC_JAL};
    endfunction

    function automatic logic [31:0] csr_write_reg(input logic [4:0] rs1);
        return enc_i(`RV_CSR_TOHOST, rs1, `RV_F3_CSRRW, 5'd0, `RV_OPC_SYSTEM);
    endfunction

    function automatic logic [31:0] csr_write_imm(input logic [4:0] uimm);
        return enc_i(`RV_CSR_TOHOST, uimm, `RV_F3_CSRRWI, 5'd0, `RV_OPC_SYSTEM);
    endfunction

    function automatic void emit(input logic [31:0] word, input string name);
        prog.push_back(word);
        names.push_back(name);
    endfunction

    function automatic void build_program();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd, d1, d2;
        logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int i = 1; i < 32; i++) begin
            emit(enc_i(12'(next_rand() >> 20), 5'd0, `RV_F3_ADD, 5'(i), `RV_OPC_OP_IMM),
                 "init");
        end
        for (int i = 0; i < 20; i++) begin
            r  = next_rand();
            f3 = r[2:0];
            rd = rand_reg();
            imm = r[31:20];
            if (f3 == `RV_F3_SLL) imm = {7'b0, r[24:20]};
            if (f3 == `RV_F3_SR) imm = {1'b0, r[8], 5'b0, r[24:20]};
            if (r[11:10] == 2'd2) begin
                emit({r[31:12], rd, `RV_OPC_LUI}, "imm_forms");
            end else if (r[11:10] == 2'd3) begin
                emit({r[31:12], rd, `RV_OPC_AUIPC}, "imm_forms");
            end else begin
                emit(enc_i(imm, rand_reg(), f3, rd, `RV_OPC_OP_IMM), "imm_forms");
            end
            emit(csr_write_reg(rd), "imm_forms");
        end
        // each op reads the two previous destinations
        d1 = 5'd1;
        d2 = 5'd2;
        for (int i = 0; i < 24; i++) begin
            r  = next_rand();
            f3 = r[2:0];
            rd = (i % 8 == 7) ? 5'd0 : rand_reg();
            emit({(f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[9], 5'b0} : 7'b0, d2, d1, f3, rd,
                  `RV_OPC_OP}, "dependences");
            emit(csr_write_reg(rd), "dependences");
            d2 = d1;
            d1 = rd;
        end
        for (int i = 0; i < 12; i++) begin
            emit(enc_i(12'(next_rand() % 3) - 12'd1, 5'd0, `RV_F3_ADD, 5'd5,
                       `RV_OPC_OP_IMM), "branches");
            emit(enc_i(12'(next_rand() % 3) - 12'd1, 5'd0, `RV_F3_ADD, 5'd6,
                       `RV_OPC_OP_IMM), "branches");
            emit(enc_b(13'd8, 5'd6, 5'd5, br_f3[i % 6]), "branches");
            emit(csr_write_imm(5'(next_rand() >> 27)), "branches");
        end
        for (int i = 0; i < 6; i++) begin
            rd = rand_reg();
            emit(enc_j(21'd8, rd), "jumps");
            emit(csr_write_imm(5'h1f), "jumps");
            emit(csr_write_reg(rd), "jumps");
            rd = rand_reg();
            emit({20'd0, 5'd7, `RV_OPC_AUIPC}, "jumps");
            emit(enc_i(12'd12, 5'd7, 3'b000, rd, `RV_OPC_JALR), "jumps");
            emit(csr_write_imm(5'h1e), "jumps");
            emit(csr_write_reg(rd), "jumps");
        end
        for (int i = 0; i < 10; i++) begin
            emit(csr_write_imm(5'(next_rand() >> 27)), "csrrwi");
        end
        emit(END_WORD, "end");
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, sa < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA-level interpreter producing the tohost sequence
    function automatic void run_reference();
        logic [31:0] x [32];
        logic [31:0] pc, next_pc, w, res, immi, immb, immj, idx;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic        wr, taken;
        for (int i = 0; i < 32; i++) x[i] = '0;
        pc = `RV_RESET_PC;
        for (int steps = 0; steps < 10000; steps++) begin
            idx = (pc - `RV_RESET_PC) >> 2;
            if (idx >= prog.size() || prog[idx] == END_WORD) break;
            w    = prog[idx];
            rd   = w[11:7];
            f3   = w[14:12];
            rs1  = w[19:15];
            rs2  = w[24:20];
            immi = {{20{w[31]}}, w[31:20]};
            immb = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            immj = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 4;
            wr  = 1'b1;
            res = '0;
            case (w[6:0])
                `RV_OPC_OP:     res = alu_ref(f3, w[30], x[rs1], x[rs2]);
                `RV_OPC_OP_IMM: res = alu_ref(f3, f3 == 3'd5 && w[30], x[rs1], immi);
                `RV_OPC_LUI:    res = {w[31:12], 12'b0};
                `RV_OPC_AUIPC:  res = pc + {w[31:12], 12'b0};
                `RV_OPC_JAL: begin
                    res = pc + 4;
                    next_pc = pc + immj;
                end
                `RV_OPC_JALR: begin
                    res = pc + 4;
                    next_pc = (x[rs1] + immi) & ~32'd1;
                end
                `RV_OPC_BRANCH: begin
                    wr = 1'b0;
                    case (f3)
                        3'd0: taken = x[rs1] == x[rs2];
                        3'd1: taken = x[rs1] != x[rs2];
                        3'd4: taken = $signed(x[rs1]) < $signed(x[rs2]);
                        3'd5: taken = $signed(x[rs1]) >= $signed(x[rs2]);
                        3'd6: taken = x[rs1] < x[rs2];
                        default: taken = x[rs1] >= x[rs2];
                    endcase
                    if (taken) next_pc = pc + immb;
                end
                default: begin
                    wr = 1'b0;
                    if (w[6:0] == `RV_OPC_SYSTEM && w[31:20] == `RV_CSR_TOHOST) begin
                        if (f3 == `RV_F3_CSRRW) exp_val.push_back(x[rs1]);
                        if (f3 == `RV_F3_CSRRWI) exp_val.push_back({27'b0, rs1});
                        if (f3 == `RV_F3_CSRRW || f3 == `RV_F3_CSRRWI)
                            exp_name.push_back(names[idx]);
                    end
                end
            endcase
            if (wr && rd != 5'd0) x[rd] = res;
            pc = next_pc;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
            errors++;
        end
    endtask

    // compares each tohost write with the reference sequence
    initial begin
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (reset !== 1'b0 && cnt < 100);
        foreach (exp_val[i]) begin
            cnt = 0;
            do begin
                @(negedge clk);
                cnt++;
            end while (tohost_valid !== 1'b1 && cnt < 200);
            if (tohost_valid !== 1'b1) begin
                $display("timeout: expected tohost write %0d (%s) never came", i, exp_name[i]);
                errors++;
                break;
            end
            check(exp_name[i], exp_val[i], tohost);
            checked++;
        end
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (tohost_valid === 1'b1) begin
                $display("unexpected tohost write of %08h after the program ended", tohost);
                errors++;
            end
        end
        done = 1'b1;
    end

    initial begin
        int cnt;
        reset = 1'b1;
        inst_data = `RV_NOP;
        build_program();
        run_reference();
        @(negedge clk);
        check("reset", `RV_RESET_PC, inst_addr);
        check("reset", 32'd0, {31'b0, tohost_valid});
        @(negedge clk);
        check("reset", `RV_RESET_PC, inst_addr);
        check("reset", 32'd0, {31'b0, tohost_valid});
        reset = 1'b0;
        // inst_addr moves to the second word as soon as reset drops
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            check("first_fetch", `RV_RESET_PC + 32'(4 * (i + 1)), inst_addr);
        end
        cnt = 0;
        while (!done && cnt < 5000) begin
            @(negedge clk);
            cnt++;
        end
        if (!done) begin
            $display("compare process did not finish in time");
            errors++;
        end
        $display("errors: %0d, tohost writes checked: %0d of %0d", errors, checked,
                 exp_val.size());
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_reg_file.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
bench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module rv_core_tb -f sim.f -o rv_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/rv_sim > sim.log 2>&1 || { echo "simulation error, see sim.log"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
